// File: hdl/game_state_decoder.sv
/*
 * Game-state decoder
 * Latches the wide state word on the frame strobe and splits it into
 * ship, torpedo and bullet positions, stop masks and the start flag
 */
`timescale 1ns/10ps

module game_state_decoder (
    input  logic                                     Clk,
    input  logic                                     rst_n,
    input  logic                                     state_load,
    input  logic [space_duel_pkg::STATE_W-1:0]       game_word,
    output space_duel_pkg::coord_t [1:0]             ship_x,
    output space_duel_pkg::coord_t [1:0]             ship_y,
    output space_duel_pkg::coord_t [1:0][space_duel_pkg::PROJ_COUNT-1:0] torp_x,
    output space_duel_pkg::coord_t [1:0][space_duel_pkg::PROJ_COUNT-1:0] torp_y,
    output space_duel_pkg::coord_t [1:0][space_duel_pkg::PROJ_COUNT-1:0] bullet_x,
    output space_duel_pkg::coord_t [1:0][space_duel_pkg::PROJ_COUNT-1:0] bullet_y,
    output space_duel_pkg::proj_mask_t [1:0]         torp_stop,
    output space_duel_pkg::proj_mask_t [1:0]         bullet_stop,
    output logic                                     game_started
);
    import space_duel_pkg::*;

    // Coordinate field from the low bits of a slot
    function automatic coord_t coord_at(input int unsigned idx);
        return game_word[idx*SLOT_W +: COORD_W];
    endfunction

    // Stop mask field from the low bits of a slot
    function automatic proj_mask_t mask_at(input int unsigned idx);
        return game_word[idx*SLOT_W +: PROJ_COUNT];
    endfunction

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            ship_x       <= '0;
            ship_y       <= '0;
            torp_x       <= '0;
            torp_y       <= '0;
            bullet_x     <= '0;
            bullet_y     <= '0;
            torp_stop    <= '0;
            bullet_stop  <= '0;
            game_started <= 1'b0;
        end else if (state_load) begin
            ship_x[0] <= coord_at(SLOT_SHIP1_X);
            ship_y[0] <= coord_at(SLOT_SHIP1_Y);
            ship_x[1] <= coord_at(SLOT_SHIP2_X);
            ship_y[1] <= coord_at(SLOT_SHIP2_Y);

            // Projectile groups take consecutive slots
            for (int i = 0; i < PROJ_COUNT; i++) begin
                torp_x[0][i]   <= coord_at(SLOT_TORP1_X + i);
                torp_y[0][i]   <= coord_at(SLOT_TORP1_Y + i);
                torp_x[1][i]   <= coord_at(SLOT_TORP2_X + i);
                torp_y[1][i]   <= coord_at(SLOT_TORP2_Y + i);
                bullet_x[0][i] <= coord_at(SLOT_BUL1_X + i);
                bullet_y[0][i] <= coord_at(SLOT_BUL1_Y + i);
                bullet_x[1][i] <= coord_at(SLOT_BUL2_X + i);
                bullet_y[1][i] <= coord_at(SLOT_BUL2_Y + i);
            end

            torp_stop[0]   <= mask_at(SLOT_TORP1_STOP);
            torp_stop[1]   <= mask_at(SLOT_TORP2_STOP);
            bullet_stop[0] <= mask_at(SLOT_BUL1_STOP);
            bullet_stop[1] <= mask_at(SLOT_BUL2_STOP);
            game_started   <= game_word[SLOT_GAME_START*SLOT_W];
        end
    end

    // An unknown frame strobe would corrupt a whole frame of state
    a_load_known : assert property (
        @(posedge Clk) disable iff (!rst_n) !$isunknown(state_load)
    );

endmodule

// File: hdl/object_hit_array.sv
/*
 * Box hit test for a group of same-sized square objects
 * Registers one hit bit per object for the current pixel
 */
`timescale 1ns/10ps

module object_hit_array #(
    parameter int COUNT = 4,
    parameter int SIZE  = 8
) (
    input  logic                                 Clk,
    input  logic                                 rst_n,
    input  space_duel_pkg::coord_t               draw_x,
    input  space_duel_pkg::coord_t               draw_y,
    input  space_duel_pkg::coord_t [COUNT-1:0]   obj_x,
    input  space_duel_pkg::coord_t [COUNT-1:0]   obj_y,
    output logic [COUNT-1:0]                     hit
);
    import space_duel_pkg::*;

    // One extra bit keeps the far edge from wrapping
    localparam int EXT_W = COORD_W + 1;

    logic [COUNT-1:0] hit_next;

    // True when pix lies in [pos, pos + SIZE - 1]
    function automatic logic in_span(input coord_t pix, input coord_t pos);
        logic [EXT_W-1:0] first;
        logic [EXT_W-1:0] last;
        first = {1'b0, pos};
        last  = first + EXT_W'(SIZE - 1);
        return ({1'b0, pix} >= first) && ({1'b0, pix} <= last);
    endfunction

    // --------------------------------------------------
    // Per-object compare
    // --------------------------------------------------
    always_comb begin
        for (int i = 0; i < COUNT; i++) begin
            hit_next[i] = in_span(draw_x, obj_x[i]) && in_span(draw_y, obj_y[i]);
        end
    end

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            hit <= '0;
        end else begin
            hit <= hit_next;  // Lines up with the delayed pixel valid
        end
    end

endmodule

// File: hdl/pixel_priority_mixer.sv
/*
 * Pixel priority mixer
 * Picks one colour from the hit vectors and registers the RGB output
 */
`timescale 1ns/10ps

module pixel_priority_mixer (
    input  logic                              Clk,
    input  logic                              rst_n,
    input  logic                              hit_valid,
    input  logic [1:0]                        ship_hit,
    input  space_duel_pkg::proj_mask_t [1:0]  torp_hit,
    input  space_duel_pkg::proj_mask_t [1:0]  bullet_hit,
    output logic                              rgb_valid,
    output space_duel_pkg::color_t            vga_r,
    output space_duel_pkg::color_t            vga_g,
    output space_duel_pkg::color_t            vga_b
);
    import space_duel_pkg::*;

    rgb_t pick;
    rgb_t color_q;

    // --------------------------------------------------
    // Fixed priority select
    // --------------------------------------------------
    always_comb begin
        if (ship_hit[0]) begin
            pick = COLOR_SHIP1;           // Ship 1 on top of everything
        end else if (ship_hit[1]) begin
            pick = COLOR_SHIP2;
        end else if (|torp_hit[0]) begin
            pick = COLOR_TORP1;
        end else if (|torp_hit[1]) begin
            pick = COLOR_TORP2;
        end else if (|bullet_hit) begin
            pick = COLOR_BULLET;          // Same for both players
        end else begin
            pick = COLOR_BACKGROUND;
        end
    end

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            rgb_valid <= 1'b0;
            color_q   <= '0;
        end else begin
            rgb_valid <= hit_valid;
            color_q   <= pick;
        end
    end

    assign vga_r = color_q.r;
    assign vga_g = color_q.g;
    assign vga_b = color_q.b;

    // Output valid is the hit valid one cycle later, with no gaps or extras
    a_valid_delay : assert property (
        @(posedge Clk) disable iff (!rst_n) rgb_valid == $past(hit_valid)
    );

endmodule

// File: hdl/space_duel_pkg.sv
/*
 * Space duel renderer shared definitions
 * Coordinate and colour types, game-state slot map, object box sizes
 */
package space_duel_pkg;

    // --------------------------------------------------
    // Widths and types
    // --------------------------------------------------
    localparam int COORD_W = 10;
    localparam int SLOT_W  = 32;
    localparam int STATE_W = 2048;   // 64 slots of 32 bits

    typedef logic [COORD_W-1:0] coord_t;
    typedef logic [7:0]         color_t;

    typedef struct packed {
        color_t r;
        color_t g;
        color_t b;
    } rgb_t;

    // --------------------------------------------------
    // Game-state word slot map
    // --------------------------------------------------
    // Each field sits in the low bits of its slot
    localparam int SLOT_SHIP1_X    = 1;
    localparam int SLOT_SHIP1_Y    = 2;
    localparam int SLOT_SHIP2_X    = 8;
    localparam int SLOT_SHIP2_Y    = 9;
    localparam int SLOT_TORP1_X    = 12;  // 4 consecutive slots
    localparam int SLOT_TORP1_Y    = 16;
    localparam int SLOT_TORP2_X    = 26;
    localparam int SLOT_TORP2_Y    = 30;
    localparam int SLOT_TORP1_STOP = 37;
    localparam int SLOT_TORP2_STOP = 38;
    localparam int SLOT_GAME_START = 44;  // Bit 0 only
    localparam int SLOT_BUL1_STOP  = 45;
    localparam int SLOT_BUL2_STOP  = 46;
    localparam int SLOT_BUL1_X     = 47;
    localparam int SLOT_BUL1_Y     = 51;
    localparam int SLOT_BUL2_X     = 55;
    localparam int SLOT_BUL2_Y     = 59;

    // Object counts and box sides in pixels
    localparam int PROJ_COUNT  = 4;
    localparam int SHIP_SIZE   = 32;
    localparam int TORP_SIZE   = 8;
    localparam int BULLET_SIZE = 4;

    typedef logic [PROJ_COUNT-1:0] proj_mask_t;  // Set bit hides that slot

    // --------------------------------------------------
    // Palette
    // --------------------------------------------------
    localparam rgb_t COLOR_SHIP1      = '{r: 8'h00, g: 8'h00, b: 8'hff};
    localparam rgb_t COLOR_SHIP2      = '{r: 8'hff, g: 8'h00, b: 8'h00};
    localparam rgb_t COLOR_TORP1      = '{r: 8'h80, g: 8'hc0, b: 8'hff};
    localparam rgb_t COLOR_TORP2      = '{r: 8'hff, g: 8'ha5, b: 8'h00};
    localparam rgb_t COLOR_BULLET     = '{r: 8'hff, g: 8'hff, b: 8'hff};
    localparam rgb_t COLOR_BACKGROUND = '{r: 8'h00, g: 8'h00, b: 8'h00};

endpackage

// File: hdl/space_duel_renderer.sv
/*
 * Space duel playfield renderer
 * Decoder, hit stage and priority mixer; colour lands two cycles after the pixel
 */
`timescale 1ns/10ps

module space_duel_renderer (
    input  logic                               Clk,
    input  logic                               rst_n,
    input  logic                               state_load,
    input  logic [space_duel_pkg::STATE_W-1:0] game_word,
    input  logic                               pixel_valid,
    input  space_duel_pkg::coord_t             draw_x,
    input  space_duel_pkg::coord_t             draw_y,
    output logic                               rgb_valid,
    output space_duel_pkg::color_t             vga_r,
    output space_duel_pkg::color_t             vga_g,
    output space_duel_pkg::color_t             vga_b
);
    import space_duel_pkg::*;

    // Decoded game state
    coord_t [1:0]                 ship_x;
    coord_t [1:0]                 ship_y;
    coord_t [1:0][PROJ_COUNT-1:0] torp_x;
    coord_t [1:0][PROJ_COUNT-1:0] torp_y;
    coord_t [1:0][PROJ_COUNT-1:0] bullet_x;
    coord_t [1:0][PROJ_COUNT-1:0] bullet_y;
    proj_mask_t [1:0]             torp_stop;
    proj_mask_t [1:0]             bullet_stop;
    logic                         game_started;

    // Hit stage to mixer
    logic                         hit_valid;
    logic [1:0]                   ship_hit;
    proj_mask_t [1:0]             torp_hit;
    proj_mask_t [1:0]             bullet_hit;

    game_state_decoder u_decoder (
        .Clk          (Clk),
        .rst_n        (rst_n),
        .state_load   (state_load),
        .game_word    (game_word),
        .ship_x       (ship_x),
        .ship_y       (ship_y),
        .torp_x       (torp_x),
        .torp_y       (torp_y),
        .bullet_x     (bullet_x),
        .bullet_y     (bullet_y),
        .torp_stop    (torp_stop),
        .bullet_stop  (bullet_stop),
        .game_started (game_started)
    );

    sprite_hit_stage u_hit_stage (
        .Clk          (Clk),
        .rst_n        (rst_n),
        .pixel_valid  (pixel_valid),
        .draw_x       (draw_x),
        .draw_y       (draw_y),
        .ship_x       (ship_x),
        .ship_y       (ship_y),
        .torp_x       (torp_x),
        .torp_y       (torp_y),
        .bullet_x     (bullet_x),
        .bullet_y     (bullet_y),
        .torp_stop    (torp_stop),
        .bullet_stop  (bullet_stop),
        .game_started (game_started),
        .hit_valid    (hit_valid),
        .ship_hit     (ship_hit),
        .torp_hit     (torp_hit),
        .bullet_hit   (bullet_hit)
    );

    pixel_priority_mixer u_mixer (
        .Clk        (Clk),
        .rst_n      (rst_n),
        .hit_valid  (hit_valid),
        .ship_hit   (ship_hit),
        .torp_hit   (torp_hit),
        .bullet_hit (bullet_hit),
        .rgb_valid  (rgb_valid),
        .vga_r      (vga_r),
        .vga_g      (vga_g),
        .vga_b      (vga_b)
    );

endmodule

// File: hdl/sprite_hit_stage.sv
/*
 * Sprite hit stage
 * Tests the pixel against every ship, torpedo and bullet box, then masks
 * projectile hits with the start flag and the per-slot stop bits
 */
`timescale 1ns/10ps

module sprite_hit_stage (
    input  logic                                     Clk,
    input  logic                                     rst_n,
    input  logic                                     pixel_valid,
    input  space_duel_pkg::coord_t                   draw_x,
    input  space_duel_pkg::coord_t                   draw_y,
    input  space_duel_pkg::coord_t [1:0]             ship_x,
    input  space_duel_pkg::coord_t [1:0]             ship_y,
    input  space_duel_pkg::coord_t [1:0][space_duel_pkg::PROJ_COUNT-1:0] torp_x,
    input  space_duel_pkg::coord_t [1:0][space_duel_pkg::PROJ_COUNT-1:0] torp_y,
    input  space_duel_pkg::coord_t [1:0][space_duel_pkg::PROJ_COUNT-1:0] bullet_x,
    input  space_duel_pkg::coord_t [1:0][space_duel_pkg::PROJ_COUNT-1:0] bullet_y,
    input  space_duel_pkg::proj_mask_t [1:0]         torp_stop,
    input  space_duel_pkg::proj_mask_t [1:0]         bullet_stop,
    input  logic                                     game_started,
    output logic                                     hit_valid,
    output logic [1:0]                               ship_hit,
    output space_duel_pkg::proj_mask_t [1:0]         torp_hit,
    output space_duel_pkg::proj_mask_t [1:0]         bullet_hit
);
    import space_duel_pkg::*;

    logic             started_q;
    proj_mask_t [1:0] torp_stop_q;
    proj_mask_t [1:0] bullet_stop_q;
    logic [1:0]       ship_raw;
    proj_mask_t [1:0] torp_raw;
    proj_mask_t [1:0] bullet_raw;

    // --------------------------------------------------
    // Box tests
    // --------------------------------------------------
    object_hit_array #(
        .COUNT (2),
        .SIZE  (SHIP_SIZE)
    ) u_ship_hit (
        .Clk    (Clk),
        .rst_n  (rst_n),
        .draw_x (draw_x),
        .draw_y (draw_y),
        .obj_x  (ship_x),
        .obj_y  (ship_y),
        .hit    (ship_raw)
    );

    for (genvar p = 0; p < 2; p++) begin : g_player
        object_hit_array #(
            .COUNT (PROJ_COUNT),
            .SIZE  (TORP_SIZE)
        ) u_torp_hit (
            .Clk    (Clk),
            .rst_n  (rst_n),
            .draw_x (draw_x),
            .draw_y (draw_y),
            .obj_x  (torp_x[p]),
            .obj_y  (torp_y[p]),
            .hit    (torp_raw[p])
        );

        object_hit_array #(
            .COUNT (PROJ_COUNT),
            .SIZE  (BULLET_SIZE)
        ) u_bullet_hit (
            .Clk    (Clk),
            .rst_n  (rst_n),
            .draw_x (draw_x),
            .draw_y (draw_y),
            .obj_x  (bullet_x[p]),
            .obj_y  (bullet_y[p]),
            .hit    (bullet_raw[p])
        );
    end

    // Gating state travels with the pixel so it matches the raw hits
    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_valid     <= 1'b0;
            started_q     <= 1'b0;
            torp_stop_q   <= '0;
            bullet_stop_q <= '0;
        end else begin
            hit_valid     <= pixel_valid;
            started_q     <= game_started;
            torp_stop_q   <= torp_stop;
            bullet_stop_q <= bullet_stop;
        end
    end

    always_comb begin
        ship_hit = hit_valid ? ship_raw : 2'b00;  // Ships always drawn
        for (int p = 0; p < 2; p++) begin
            torp_hit[p]   = (hit_valid && started_q) ? (torp_raw[p] & ~torp_stop_q[p]) : '0;
            bullet_hit[p] = (hit_valid && started_q) ? (bullet_raw[p] & ~bullet_stop_q[p]) : '0;
        end
    end

    // No stale hit may leak into a cycle without a pixel
    a_hit_needs_valid : assert property (
        @(posedge Clk) disable iff (!rst_n) (|{ship_hit, torp_hit, bullet_hit}) |-> hit_valid
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the space duel renderer testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --timescale 1ns/10ps \
    --top-module space_duel_renderer_tb -f space_duel_renderer.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run exited with status $status"
    exit 1
fi

if grep -q "^Simulation completed successfully$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: space_duel_renderer.f
+incdir+include
hdl/space_duel_pkg.sv
hdl/game_state_decoder.sv
hdl/object_hit_array.sv
hdl/sprite_hit_stage.sv
hdl/pixel_priority_mixer.sv
hdl/space_duel_renderer.sv
tests/space_duel_renderer_tb.sv

// File: include/renderer_tb_vectors.svh
/*
 * Renderer testbench vectors
 * Scene setups and pixel rows with the colour class each pixel should show
 */
`ifndef RENDERER_TB_VECTORS_SVH
`define RENDERER_TB_VECTORS_SVH

// Colour classes
localparam int CLS_BACK   = 0;
localparam int CLS_SHIP1  = 1;
localparam int CLS_SHIP2  = 2;
localparam int CLS_TORP1  = 3;
localparam int CLS_TORP2  = 4;
localparam int CLS_BULLET = 5;

localparam int NUM_SCENES = 4;
localparam int NUM_ROWS   = 41;

// Scene columns are start flag, ship 1 x y, ship 2 x y, torpedo 1 x y, torpedo 2 x y,
// bullet 1 x y, bullet 2 x y, then stop masks for torpedo 1, torpedo 2, bullet 1, bullet 2
// Projectile slot i sits 16*i pixels right of its group's x
int scene_tab [NUM_SCENES][17] = '{
    '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},          // Reset state, never loaded
    '{0, 100, 100, 300, 100, 100, 200, 200, 200, 100, 300, 200, 300, 0, 0, 0, 0},
    '{1, 100, 100, 120, 120, 100, 200, 104, 104, 102, 202, 110, 110, 2, 0, 2, 8},
    '{1, 400, 40, 600, 40, 900, 900, 900, 930, 900, 960, 900, 990, 0, 0, 0, 0}
};

// Pixel rows as scene, x, y, expected class
int pix_tab [NUM_ROWS][4] = '{
    '{0, 100, 100, CLS_BACK},   '{0, 500, 500, CLS_BACK},
    '{1, 100, 100, CLS_SHIP1},  '{1, 131, 131, CLS_SHIP1},
    '{1, 132, 100, CLS_BACK},   '{1, 100, 132, CLS_BACK},
    '{1, 99, 100, CLS_BACK},    '{1, 300, 100, CLS_SHIP2},
    '{1, 331, 131, CLS_SHIP2},  '{1, 332, 131, CLS_BACK},
    '{1, 100, 200, CLS_BACK},   '{1, 202, 202, CLS_BACK},     // Not started yet
    '{1, 101, 301, CLS_BACK},   '{1, 140, 140, CLS_BACK},
    '{2, 110, 110, CLS_SHIP1},  '{2, 125, 125, CLS_SHIP1},    // Ship 1 over the rest
    '{2, 140, 140, CLS_SHIP2},  '{2, 151, 151, CLS_SHIP2},
    '{2, 152, 151, CLS_BACK},   '{2, 136, 104, CLS_TORP2},
    '{2, 143, 111, CLS_TORP2},  '{2, 144, 104, CLS_BACK},
    '{2, 145, 113, CLS_BULLET}, '{2, 160, 112, CLS_BACK},     // Bullet slot 3 stopped
    '{2, 103, 203, CLS_TORP1},  '{2, 100, 200, CLS_TORP1},
    '{2, 107, 207, CLS_TORP1},  '{2, 116, 200, CLS_BACK},     // Torpedo slot 1 stopped
    '{2, 120, 203, CLS_BACK},   '{2, 132, 200, CLS_TORP1},
    '{2, 110, 110, CLS_SHIP1},  '{3, 110, 110, CLS_BACK},
    '{3, 400, 40, CLS_SHIP1},   '{3, 431, 71, CLS_SHIP1},
    '{3, 432, 40, CLS_BACK},    '{3, 600, 40, CLS_SHIP2},
    '{3, 631, 71, CLS_SHIP2},   '{3, 900, 900, CLS_TORP1},
    '{3, 900, 930, CLS_TORP2},  '{3, 903, 963, CLS_BULLET},
    '{3, 949, 993, CLS_BULLET}
};

`endif

// File: tests/space_duel_renderer_tb.sv
/*
 * Space duel renderer testbench
 * Streams table pixels across scene loads and checks each colour two cycles later
 */
`timescale 1ns/10ps

module space_duel_renderer_tb;
    import space_duel_pkg::*;

    `include "renderer_tb_vectors.svh"

    localparam int RESET_CYCLES = 16;
    localparam int RAND_PIXELS  = 8;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + (NUM_ROWS + RAND_PIXELS) * 4 + 100;

    logic               Clk;
    logic               rst_n;
    logic               state_load;
    logic [STATE_W-1:0] game_word;
    logic               pixel_valid;
    coord_t             draw_x;
    coord_t             draw_y;
    logic               rgb_valid;
    color_t             vga_r;
    color_t             vga_g;
    color_t             vga_b;

    int seed;
    int cycle_count = 0;
    int cur_scene;
    int exp_q[$];   // Expected class per cycle, -1 for no pixel

    space_duel_renderer dut_i (
        .Clk         (Clk),
        .rst_n       (rst_n),
        .state_load  (state_load),
        .game_word   (game_word),
        .pixel_valid (pixel_valid),
        .draw_x      (draw_x),
        .draw_y      (draw_y),
        .rgb_valid   (rgb_valid),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b)
    );

    initial begin
        Clk = 1'b0;
        forever #20 Clk = ~Clk;
    end

    // Run limit
    always @(posedge Clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_valid(input logic exp);
        if (rgb_valid !== exp) begin
            report_error($sformatf("rgb_valid is %b, expected %b", rgb_valid, exp));
        end
    endtask

    task automatic check_color(input color_t exp_r, input color_t exp_g, input color_t exp_b);
        if ({vga_r, vga_g, vga_b} !== {exp_r, exp_g, exp_b}) begin
            report_error($sformatf("colour %h_%h_%h, expected %h_%h_%h",
                vga_r, vga_g, vga_b, exp_r, exp_g, exp_b));
        end
    endtask

    function automatic rgb_t class_color(input int cls);
        case (cls)
            CLS_SHIP1:  return COLOR_SHIP1;
            CLS_SHIP2:  return COLOR_SHIP2;
            CLS_TORP1:  return COLOR_TORP1;
            CLS_TORP2:  return COLOR_TORP2;
            CLS_BULLET: return COLOR_BULLET;
            default:    return COLOR_BACKGROUND;
        endcase
    endfunction

    // Packs one scene row into the game-state slots
    function automatic logic [STATE_W-1:0] build_word(input int sc);
        logic [STATE_W-1:0] w;
        w = '0;
        w[SLOT_GAME_START*SLOT_W]         = scene_tab[sc][0][0];
        w[SLOT_SHIP1_X*SLOT_W +: COORD_W] = coord_t'(scene_tab[sc][1]);
        w[SLOT_SHIP1_Y*SLOT_W +: COORD_W] = coord_t'(scene_tab[sc][2]);
        w[SLOT_SHIP2_X*SLOT_W +: COORD_W] = coord_t'(scene_tab[sc][3]);
        w[SLOT_SHIP2_Y*SLOT_W +: COORD_W] = coord_t'(scene_tab[sc][4]);
        for (int i = 0; i < PROJ_COUNT; i++) begin
            w[(SLOT_TORP1_X+i)*SLOT_W +: COORD_W] = coord_t'(scene_tab[sc][5] + 16*i);
            w[(SLOT_TORP1_Y+i)*SLOT_W +: COORD_W] = coord_t'(scene_tab[sc][6]);
            w[(SLOT_TORP2_X+i)*SLOT_W +: COORD_W] = coord_t'(scene_tab[sc][7] + 16*i);
            w[(SLOT_TORP2_Y+i)*SLOT_W +: COORD_W] = coord_t'(scene_tab[sc][8]);
            w[(SLOT_BUL1_X+i)*SLOT_W +: COORD_W]  = coord_t'(scene_tab[sc][9] + 16*i);
            w[(SLOT_BUL1_Y+i)*SLOT_W +: COORD_W]  = coord_t'(scene_tab[sc][10]);
            w[(SLOT_BUL2_X+i)*SLOT_W +: COORD_W]  = coord_t'(scene_tab[sc][11] + 16*i);
            w[(SLOT_BUL2_Y+i)*SLOT_W +: COORD_W]  = coord_t'(scene_tab[sc][12]);
        end
        w[SLOT_TORP1_STOP*SLOT_W +: PROJ_COUNT] = proj_mask_t'(scene_tab[sc][13]);
        w[SLOT_TORP2_STOP*SLOT_W +: PROJ_COUNT] = proj_mask_t'(scene_tab[sc][14]);
        w[SLOT_BUL1_STOP*SLOT_W +: PROJ_COUNT]  = proj_mask_t'(scene_tab[sc][15]);
        w[SLOT_BUL2_STOP*SLOT_W +: PROJ_COUNT]  = proj_mask_t'(scene_tab[sc][16]);
        return w;
    endfunction

    // One falling edge: check the pixel from two cycles back, then drive
    task automatic drive_cycle(input logic load, input logic valid,
                               input int x, input int y, input int cls);
        int   exp_cls;
        rgb_t exp_rgb;
        @(negedge Clk);
        exp_q.push_back(valid ? cls : -1);
        if (exp_q.size() > 2) begin
            exp_cls = exp_q.pop_front();
            check_valid(exp_cls >= 0);
            if (exp_cls >= 0) begin
                exp_rgb = class_color(exp_cls);
                check_color(exp_rgb.r, exp_rgb.g, exp_rgb.b);
            end
        end
        state_load  = load;
        pixel_valid = valid;
        draw_x      = coord_t'(x);
        draw_y      = coord_t'(y);
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        seed        = 32'h2e44_7950;
        rst_n       = 1'b0;
        state_load  = 1'b0;
        game_word   = '0;
        pixel_valid = 1'b0;
        draw_x      = '0;
        draw_y      = '0;
        cur_scene   = 0;
        repeat (RESET_CYCLES) @(negedge Clk);
        rst_n = 1'b1;
        repeat (3) drive_cycle(1'b0, 1'b0, 0, 0, CLS_BACK);   // rgb_valid stays low

        for (int r = 0; r < NUM_ROWS; r++) begin
            if (pix_tab[r][0] != cur_scene) begin
                // Load cycle repeats the last pixel, which must still see the old scene
                game_word = build_word(pix_tab[r][0]);
                drive_cycle(1'b1, 1'b1, pix_tab[r-1][1], pix_tab[r-1][2], pix_tab[r-1][3]);
                cur_scene = pix_tab[r][0];
            end
            drive_cycle(1'b0, 1'b1, pix_tab[r][1], pix_tab[r][2], pix_tab[r][3]);
        end

        // Empty field well away from every object
        for (int n = 0; n < RAND_PIXELS; n++) begin
            drive_cycle(1'b0, 1'b1, 512 + ($random(seed) & 255),
                        512 + ($random(seed) & 255), CLS_BACK);
        end
        repeat (4) drive_cycle(1'b0, 1'b0, 0, 0, CLS_BACK);   // Drain and see rgb_valid drop

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
